//--- verilog/hpav_interleaver_pkg.sv
package hpav_interleaver_pkg;

    localparam int D_WIDTH = 2;     // symbol width
    localparam int A_WIDTH = 12;    // linear and bank address width
    localparam int LATENCY = 3;     // step issue to dout_vld

    typedef logic [1:0] lane_t;

    typedef enum logic [1:0] {
        PB16,
        PB136,
        PB520
    } pb_size_t;

    typedef enum logic {
        DEINTERLEAVE,
        INTERLEAVE
    } il_mode_t;

    // ------------------------------------------------------------------------
    // block geometry
    // ------------------------------------------------------------------------

    function automatic logic [A_WIDTH-1:0] quarter_len(pb_size_t size);
        case (size)
            PB136:   return A_WIDTH'(136);
            PB520:   return A_WIDTH'(520);
            default: return A_WIDTH'(16);
        endcase
    endfunction

    function automatic logic [A_WIDTH-1:0] block_len(pb_size_t size);
        return quarter_len(size) << 2;
    endfunction

    // separate bank regions so blocks of different sizes coexist
    function automatic logic [A_WIDTH-1:0] region_base(pb_size_t size);
        case (size)
            PB136:   return A_WIDTH'(16);
            PB520:   return A_WIDTH'(152);
            default: return A_WIDTH'(0);
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // each stride pair is a multiplicative inverse mod N
    // ------------------------------------------------------------------------

    function automatic logic [A_WIDTH-1:0] stride(pb_size_t size, il_mode_t mode);
        case (size)
            PB136:   return (mode == INTERLEAVE) ? A_WIDTH'(5) : A_WIDTH'(109);
            PB520:   return (mode == INTERLEAVE) ? A_WIDTH'(7) : A_WIDTH'(1783);
            default: return (mode == INTERLEAVE) ? A_WIDTH'(13) : A_WIDTH'(5);
        endcase
    endfunction

endpackage

//--- verilog/interleave_sequencer.sv
`timescale 1ns/1ns

module interleave_sequencer (
    input  logic                           clk,
    input  logic                           n_rst,
    input  logic                           start,
    input  hpav_interleaver_pkg::pb_size_t pb_size,
    input  hpav_interleaver_pkg::il_mode_t mode,
    output logic                           busy,
    output logic                           step_valid,
    output logic                           first_step,
    output hpav_interleaver_pkg::pb_size_t cur_size,
    output hpav_interleaver_pkg::il_mode_t cur_mode,
    output logic                           dout_vld
);

    import hpav_interleaver_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } state_t;

    state_t             state;
    logic [A_WIDTH-1:0] step_cnt;   // step index in RUN, drain count in DRAIN
    logic [A_WIDTH-1:0] last_step;
    logic [LATENCY-1:0] vld_pipe;

    assign last_step = quarter_len(cur_size) - 1'b1;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            step_cnt <= '0;
            cur_size <= PB16;
            cur_mode <= DEINTERLEAVE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin    // start while busy never reaches here
                        state    <= RUN;
                        step_cnt <= '0;
                        cur_size <= pb_size;
                        cur_mode <= mode;
                    end
                end
                RUN: begin
                    if (step_cnt == last_step) begin
                        state    <= DRAIN;
                        step_cnt <= '0;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    // wait for the last step to leave the pipeline
                    if (step_cnt == A_WIDTH'(LATENCY - 1)) begin
                        state    <= IDLE;
                        step_cnt <= '0;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy       = (state != IDLE);
    assign step_valid = (state == RUN);
    assign first_step = step_valid && (step_cnt == '0);

    // valid follows each step through the three pipeline stages
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LATENCY-2:0], step_valid};
        end
    end

    assign dout_vld = vld_pipe[LATENCY-1];

endmodule

//--- verilog/permutation_generator.sv
`timescale 1ns/1ns

module permutation_generator #(
    parameter int A_WIDTH = hpav_interleaver_pkg::A_WIDTH
) (
    input  logic                           clk,
    input  logic                           n_rst,
    input  logic                           step_valid,
    input  logic                           first_step,
    input  hpav_interleaver_pkg::pb_size_t cur_size,
    input  hpav_interleaver_pkg::il_mode_t cur_mode,
    output logic [A_WIDTH-1:0]             pos0,
    output logic [A_WIDTH-1:0]             pos1,
    output logic [A_WIDTH-1:0]             pos2,
    output logic [A_WIDTH-1:0]             pos3
);

    import hpav_interleaver_pkg::*;

    logic [A_WIDTH-1:0] q;
    logic [A_WIDTH-1:0] n;
    logic [A_WIDTH-1:0] s;

    logic [A_WIDTH-1:0] acc [4];    // ((k*Q + i) * s) mod N per lane
    lane_t              mult [4];
    logic [A_WIDTH-1:0] seed [4];
    logic [A_WIDTH:0]   sum [4];
    logic [A_WIDTH-1:0] nxt [4];

    assign q = A_WIDTH'(quarter_len(cur_size));
    assign n = A_WIDTH'(block_len(cur_size));
    assign s = A_WIDTH'(stride(cur_size, cur_mode));

    // ------------------------------------------------------------------------
    // lane k starts at (k*Q*s) mod N = Q * ((k*s) mod 4), since N = 4Q
    // ------------------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            mult[k] = lane_t'(k) * s[1:0];  // 2-bit product wraps mod 4
            seed[k] = A_WIDTH'(q * mult[k]);
            sum[k]  = {1'b0, acc[k]} + {1'b0, s};
            if (sum[k] >= {1'b0, n}) begin
                nxt[k] = A_WIDTH'(sum[k] - {1'b0, n});
            end else begin
                nxt[k] = sum[k][A_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int k = 0; k < 4; k++) begin
                acc[k] <= '0;
            end
        end else if (step_valid) begin
            for (int k = 0; k < 4; k++) begin
                acc[k] <= first_step ? seed[k] : nxt[k];
            end
        end
    end

    assign pos0 = acc[0];
    assign pos1 = acc[1];
    assign pos2 = acc[2];
    assign pos3 = acc[3];

endmodule

//--- verilog/bank_crossbar.sv
`timescale 1ns/1ns

module bank_crossbar #(
    parameter int A_WIDTH = hpav_interleaver_pkg::A_WIDTH,
    parameter int D_WIDTH = hpav_interleaver_pkg::D_WIDTH
) (
    input  logic                           clk,
    input  logic                           n_rst,
    input  hpav_interleaver_pkg::pb_size_t cur_size,
    input  logic [A_WIDTH-1:0]             pos0,
    input  logic [A_WIDTH-1:0]             pos1,
    input  logic [A_WIDTH-1:0]             pos2,
    input  logic [A_WIDTH-1:0]             pos3,
    output logic [A_WIDTH-1:0]             raddr0,
    output logic [A_WIDTH-1:0]             raddr1,
    output logic [A_WIDTH-1:0]             raddr2,
    output logic [A_WIDTH-1:0]             raddr3,
    input  logic [D_WIDTH-1:0]             bank_data0,
    input  logic [D_WIDTH-1:0]             bank_data1,
    input  logic [D_WIDTH-1:0]             bank_data2,
    input  logic [D_WIDTH-1:0]             bank_data3,
    output logic [D_WIDTH-1:0]             rdata0,
    output logic [D_WIDTH-1:0]             rdata1,
    output logic [D_WIDTH-1:0]             rdata2,
    output logic [D_WIDTH-1:0]             rdata3
);

    import hpav_interleaver_pkg::*;

    logic [A_WIDTH-1:0] q1;
    logic [A_WIDTH-1:0] q2;
    logic [A_WIDTH-1:0] q3;

    logic [A_WIDTH-1:0] pos [4];
    lane_t              quarter [4];
    logic [A_WIDTH-1:0] offset [4];
    logic [A_WIDTH-1:0] raddr [4];
    lane_t              req_lane [4];   // lane served by each bank
    lane_t              req_lane_d [4];
    logic [D_WIDTH-1:0] bank_data [4];
    logic [D_WIDTH-1:0] lane_data [4];
    logic [D_WIDTH-1:0] rdata_q [4];

    assign q1 = A_WIDTH'(quarter_len(cur_size));
    assign q2 = q1 << 1;
    assign q3 = q2 + q1;

    assign pos[0] = pos0;
    assign pos[1] = pos1;
    assign pos[2] = pos2;
    assign pos[3] = pos3;

    assign bank_data[0] = bank_data0;
    assign bank_data[1] = bank_data1;
    assign bank_data[2] = bank_data2;
    assign bank_data[3] = bank_data3;

    // ------------------------------------------------------------------------
    // quarter decode and address routing in stage 2
    // ------------------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (pos[k] >= q3) begin
                quarter[k] = 2'd3;
                offset[k]  = pos[k] - q3;
            end else if (pos[k] >= q2) begin
                quarter[k] = 2'd2;
                offset[k]  = pos[k] - q2;
            end else if (pos[k] >= q1) begin
                quarter[k] = 2'd1;
                offset[k]  = pos[k] - q1;
            end else begin
                quarter[k] = 2'd0;
                offset[k]  = pos[k];
            end
        end
    end

    // odd stride puts the four lanes in four different quarters
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            raddr[b]    = '0;
            req_lane[b] = '0;
            for (int k = 0; k < 4; k++) begin
                if (quarter[k] == lane_t'(b)) begin
                    raddr[b]    = offset[k];
                    req_lane[b] = lane_t'(k);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int b = 0; b < 4; b++) begin
                req_lane_d[b] <= '0;
            end
        end else begin
            req_lane_d <= req_lane;     // lines up with registered bank data
        end
    end

    // ------------------------------------------------------------------------
    // bank data steered back to lanes in stage 3
    // ------------------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lane_data[k] = '0;
            for (int b = 0; b < 4; b++) begin
                if (req_lane_d[b] == lane_t'(k)) begin
                    lane_data[k] = bank_data[b];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int k = 0; k < 4; k++) begin
                rdata_q[k] <= '0;
            end
        end else begin
            rdata_q <= lane_data;
        end
    end

    assign raddr0 = raddr[0];
    assign raddr1 = raddr[1];
    assign raddr2 = raddr[2];
    assign raddr3 = raddr[3];

    assign rdata0 = rdata_q[0];
    assign rdata1 = rdata_q[1];
    assign rdata2 = rdata_q[2];
    assign rdata3 = rdata_q[3];

endmodule

//--- verilog/symbol_banks.sv
`timescale 1ns/1ns

module symbol_banks #(
    parameter int A_WIDTH = hpav_interleaver_pkg::A_WIDTH,
    parameter int D_WIDTH = hpav_interleaver_pkg::D_WIDTH
) (
    input  logic                           clk,
    input  logic                           wen,
    input  hpav_interleaver_pkg::lane_t    wbank,
    input  logic [A_WIDTH-1:0]             waddr,
    input  logic [D_WIDTH-1:0]             wdata,
    input  hpav_interleaver_pkg::pb_size_t cur_size,
    input  hpav_interleaver_pkg::pb_size_t pb_size,
    input  logic [A_WIDTH-1:0]             raddr0,
    input  logic [A_WIDTH-1:0]             raddr1,
    input  logic [A_WIDTH-1:0]             raddr2,
    input  logic [A_WIDTH-1:0]             raddr3,
    output logic [D_WIDTH-1:0]             bank_data0,
    output logic [D_WIDTH-1:0]             bank_data1,
    output logic [D_WIDTH-1:0]             bank_data2,
    output logic [D_WIDTH-1:0]             bank_data3
);

    import hpav_interleaver_pkg::*;

    logic [D_WIDTH-1:0] mem [4][2**A_WIDTH];    // one memory per bank

    logic [A_WIDTH-1:0] wa;
    logic [A_WIDTH-1:0] rbase;
    logic [A_WIDTH-1:0] raddr [4];
    logic [A_WIDTH-1:0] ra [4];
    logic [D_WIDTH-1:0] rd_q [4];

    // loader uses the size on pb_size, the read side the latched size
    assign wa    = waddr + A_WIDTH'(region_base(pb_size));
    assign rbase = A_WIDTH'(region_base(cur_size));

    assign raddr[0] = raddr0;
    assign raddr[1] = raddr1;
    assign raddr[2] = raddr2;
    assign raddr[3] = raddr3;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            ra[b] = raddr[b] + rbase;
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[wbank][wa] <= wdata;
        end
        for (int b = 0; b < 4; b++) begin
            rd_q[b] <= mem[b][ra[b]];   // registered read port
        end
    end

    assign bank_data0 = rd_q[0];
    assign bank_data1 = rd_q[1];
    assign bank_data2 = rd_q[2];
    assign bank_data3 = rd_q[3];

endmodule

//--- verilog/turbo_interleaver.sv
`timescale 1ns/1ns

module turbo_interleaver #(
    parameter int D_WIDTH = hpav_interleaver_pkg::D_WIDTH,
    parameter int A_WIDTH = hpav_interleaver_pkg::A_WIDTH
) (
    input  logic                           clk,
    input  logic                           n_rst,
    input  logic                           wen,
    input  hpav_interleaver_pkg::lane_t    wbank,
    input  logic [A_WIDTH-1:0]             waddr,
    input  logic [D_WIDTH-1:0]             wdata,
    input  hpav_interleaver_pkg::pb_size_t pb_size,
    input  hpav_interleaver_pkg::il_mode_t mode,
    input  logic                           start,
    output logic                           busy,
    output logic                           dout_vld,
    output logic [D_WIDTH-1:0]             rdata0,
    output logic [D_WIDTH-1:0]             rdata1,
    output logic [D_WIDTH-1:0]             rdata2,
    output logic [D_WIDTH-1:0]             rdata3
);

    import hpav_interleaver_pkg::*;

    logic               step_valid;
    logic               first_step;
    pb_size_t           cur_size;
    il_mode_t           cur_mode;

    logic [A_WIDTH-1:0] pos0;
    logic [A_WIDTH-1:0] pos1;
    logic [A_WIDTH-1:0] pos2;
    logic [A_WIDTH-1:0] pos3;

    logic [A_WIDTH-1:0] raddr0;
    logic [A_WIDTH-1:0] raddr1;
    logic [A_WIDTH-1:0] raddr2;
    logic [A_WIDTH-1:0] raddr3;

    logic [D_WIDTH-1:0] bank_data0;
    logic [D_WIDTH-1:0] bank_data1;
    logic [D_WIDTH-1:0] bank_data2;
    logic [D_WIDTH-1:0] bank_data3;

    interleave_sequencer sequencer_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .start      (start),
        .pb_size    (pb_size),
        .mode       (mode),
        .busy       (busy),
        .step_valid (step_valid),
        .first_step (first_step),
        .cur_size   (cur_size),
        .cur_mode   (cur_mode),
        .dout_vld   (dout_vld)
    );

    permutation_generator #(
        .A_WIDTH (A_WIDTH)
    ) permutation_generator_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .step_valid (step_valid),
        .first_step (first_step),
        .cur_size   (cur_size),
        .cur_mode   (cur_mode),
        .pos0       (pos0),
        .pos1       (pos1),
        .pos2       (pos2),
        .pos3       (pos3)
    );

    bank_crossbar #(
        .A_WIDTH (A_WIDTH),
        .D_WIDTH (D_WIDTH)
    ) bank_crossbar_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .cur_size   (cur_size),
        .pos0       (pos0),
        .pos1       (pos1),
        .pos2       (pos2),
        .pos3       (pos3),
        .raddr0     (raddr0),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .raddr3     (raddr3),
        .bank_data0 (bank_data0),
        .bank_data1 (bank_data1),
        .bank_data2 (bank_data2),
        .bank_data3 (bank_data3),
        .rdata0     (rdata0),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .rdata3     (rdata3)
    );

    symbol_banks #(
        .A_WIDTH (A_WIDTH),
        .D_WIDTH (D_WIDTH)
    ) symbol_banks_inst (
        .clk        (clk),
        .wen        (wen),
        .wbank      (wbank),
        .waddr      (waddr),
        .wdata      (wdata),
        .cur_size   (cur_size),
        .pb_size    (pb_size),
        .raddr0     (raddr0),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .raddr3     (raddr3),
        .bank_data0 (bank_data0),
        .bank_data1 (bank_data1),
        .bank_data2 (bank_data2),
        .bank_data3 (bank_data3)
    );

endmodule

//--- test/turbo_interleaver_properties.sv
`timescale 1ns/1ns

module turbo_interleaver_properties (
    input logic clk,
    input logic n_rst,
    input logic wen,
    input logic busy,
    input logic step_valid,
    input logic dout_vld
);

    import hpav_interleaver_pkg::*;

    // ------------------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------------------

    reset_quiet: assert property (@(posedge clk) $rose(n_rst) |-> (!dout_vld && !busy))
        else $error("dout_vld or busy high right after reset");

    // every step comes out LATENCY cycles later
    vld_after_step: assert property (@(posedge clk) disable iff (!n_rst)
        $past(step_valid, LATENCY) |-> dout_vld)
        else $error("dout_vld missing %0d cycles after a step", LATENCY);

    vld_only_from_step: assert property (@(posedge clk) disable iff (!n_rst)
        dout_vld |-> $past(step_valid, LATENCY))
        else $error("dout_vld without a step %0d cycles before", LATENCY);

    // loader stays off the banks during a read
    no_write_while_busy: assert property (@(posedge clk) disable iff (!n_rst)
        busy |-> !wen)
        else $error("bank write while busy");

endmodule

bind turbo_interleaver turbo_interleaver_properties turbo_interleaver_properties_inst (
    .clk        (clk),
    .n_rst      (n_rst),
    .wen        (wen),
    .busy       (busy),
    .step_valid (step_valid),
    .dout_vld   (dout_vld)
);

//--- test/tb_turbo_interleaver.sv
`timescale 1ns/1ns

module tb_turbo_interleaver;

    import hpav_interleaver_pkg::*;

    typedef enum logic [1:0] {
        FILL_RANDOM,
        FILL_ROUNDTRIP,     // reload the previous run's output
        FILL_KEEP
    } fill_t;

    typedef struct packed {
        pb_size_t size;
        il_mode_t mode;
        fill_t    fill;
    } row_t;

    localparam int NUM_ROWS = 9;
    localparam int MAX_N    = 2080;

    localparam int QUARTER_TAB [3] = '{16, 136, 520};
    localparam int IL_STRIDE [3]   = '{13, 5, 7};
    localparam int DIL_STRIDE [3]  = '{5, 109, 1783};

    localparam row_t STIM [NUM_ROWS] = '{
        '{PB16,  INTERLEAVE,   FILL_RANDOM},
        '{PB136, INTERLEAVE,   FILL_RANDOM},
        '{PB520, INTERLEAVE,   FILL_RANDOM},
        '{PB16,  DEINTERLEAVE, FILL_RANDOM},
        '{PB520, DEINTERLEAVE, FILL_RANDOM},
        '{PB136, DEINTERLEAVE, FILL_RANDOM},
        '{PB136, INTERLEAVE,   FILL_RANDOM},
        '{PB136, DEINTERLEAVE, FILL_ROUNDTRIP},
        '{PB16,  INTERLEAVE,   FILL_KEEP}       // PB16 block of row 3
    };

    logic               clk = 1'b0;
    logic               n_rst;
    logic               wen;
    lane_t              wbank;
    logic [A_WIDTH-1:0] waddr;
    logic [D_WIDTH-1:0] wdata;
    pb_size_t           pb_size;
    il_mode_t           mode;
    logic               start;
    logic               busy;
    logic               dout_vld;
    logic [D_WIDTH-1:0] rdata0;
    logic [D_WIDTH-1:0] rdata1;
    logic [D_WIDTH-1:0] rdata2;
    logic [D_WIDTH-1:0] rdata3;

    logic [D_WIDTH-1:0] ref_data [3][MAX_N];    // reference block per size
    logic [D_WIDTH-1:0] orig_data [MAX_N];
    logic [D_WIDTH-1:0] out_buf [MAX_N];        // last run in linear order
    logic [31:0]        rng_state;
    int                 cycle_cnt = 0;
    int                 timeout_limit = 0;

    turbo_interleaver #(
        .D_WIDTH (D_WIDTH),
        .A_WIDTH (A_WIDTH)
    ) turbo_interleaver_inst (
        .clk      (clk),
        .n_rst    (n_rst),
        .wen      (wen),
        .wbank    (wbank),
        .waddr    (waddr),
        .wdata    (wdata),
        .pb_size  (pb_size),
        .mode     (mode),
        .start    (start),
        .busy     (busy),
        .dout_vld (dout_vld),
        .rdata0   (rdata0),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .rdata3   (rdata3)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            stop_on_error();
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH @ %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [D_WIDTH-1:0] read_lane(input int k);
        case (k)
            0:       return rdata0;
            1:       return rdata1;
            2:       return rdata2;
            default: return rdata3;
        endcase
    endfunction

    // drive point 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic load_block(input pb_size_t sz);
        int s_idx;
        int q;
        s_idx   = int'(sz);
        q       = QUARTER_TAB[s_idx];
        pb_size = sz;
        for (int x = 0; x < 4 * q; x++) begin
            wen   = 1'b1;
            wbank = lane_t'(x / q);     // quarter picks the bank
            waddr = A_WIDTH'(x % q);
            wdata = ref_data[s_idx][x];
            next_cycle();
            check_value(32'(busy), 32'd0, "busy while loading");
            check_value(32'(dout_vld), 32'd0, "dout_vld while loading");
        end
        wen = 1'b0;
    endtask

    task automatic fill_block(input row_t row);
        int sz;
        int n;
        sz = int'(row.size);
        n  = 4 * QUARTER_TAB[sz];
        for (int x = 0; x < n; x++) begin
            if (row.fill == FILL_RANDOM) begin
                rng_state       = xorshift32(rng_state);
                ref_data[sz][x] = rng_state[D_WIDTH-1:0];
                orig_data[x]    = ref_data[sz][x];
            end else if (row.fill == FILL_ROUNDTRIP) begin
                ref_data[sz][x] = out_buf[x];
            end
        end
        if (row.fill != FILL_KEEP) begin
            load_block(row.size);
        end
    endtask

    // ------------------------------------------------------------------------
    // one table row loads, starts, collects Q beats and checks each lane
    // ------------------------------------------------------------------------

    task automatic run_block(input int r);
        row_t row;
        int   sz;
        int   q;
        int   n;
        int   s;
        int   beats;
        int   cyc;
        int   idx;
        row = STIM[r];
        sz  = int'(row.size);
        q   = QUARTER_TAB[sz];
        n   = 4 * q;
        s   = (row.mode == INTERLEAVE) ? IL_STRIDE[sz] : DIL_STRIDE[sz];
        fill_block(row);

        pb_size = row.size;
        mode    = row.mode;
        start   = 1'b1;
        next_cycle();
        start = 1'b0;
        check_value(32'(busy), 32'd1, $sformatf("row %0d busy after start", r));

        beats = 0;
        cyc   = 0;
        while (busy === 1'b1) begin
            start = (cyc == 1);     // stray start mid-run with the other mode
            mode  = (row.mode == INTERLEAVE) ? DEINTERLEAVE : INTERLEAVE;
            if (dout_vld === 1'b1) begin
                check_value(32'(beats < q), 32'd1, $sformatf("row %0d beat past Q", r));
                check_value(32'(cyc), 32'(LATENCY + beats),
                            $sformatf("row %0d beat %0d timing", r, beats));
                for (int k = 0; k < 4; k++) begin
                    idx = ((k * q + beats) * s) % n;
                    out_buf[k * q + beats] = read_lane(k);
                    check_value(32'(read_lane(k)), 32'(ref_data[sz][idx]),
                                $sformatf("row %0d lane %0d step %0d", r, k, beats));
                    if (row.fill == FILL_ROUNDTRIP) begin
                        check_value(32'(read_lane(k)), 32'(orig_data[k * q + beats]),
                                    $sformatf("row %0d round trip lane %0d", r, k));
                    end
                end
                beats++;
            end
            cyc++;
            next_cycle();
        end
        start = 1'b0;
        check_value(32'(beats), 32'(q), $sformatf("row %0d beat count", r));
        check_value(32'(cyc), 32'(q + LATENCY), $sformatf("row %0d busy length", r));

        // no restart and no late beats once busy has dropped
        repeat (LATENCY + 2) begin
            check_value(32'(busy), 32'd0, $sformatf("row %0d busy after run", r));
            check_value(32'(dout_vld), 32'd0, $sformatf("row %0d beat after run", r));
            next_cycle();
        end
    endtask

    initial begin
        rng_state = 32'hedf8;
        for (int r = 0; r < NUM_ROWS; r++) begin
            timeout_limit += 2 * (5 * QUARTER_TAB[int'(STIM[r].size)] + 20);
        end

        n_rst   = 1'b0;
        wen     = 1'b0;
        wbank   = '0;
        waddr   = '0;
        wdata   = '0;
        pb_size = PB16;
        mode    = DEINTERLEAVE;
        start   = 1'b0;

        repeat (5) begin
            next_cycle();
            check_value(32'(busy), 32'd0, "busy in reset");
            check_value(32'(dout_vld), 32'd0, "dout_vld in reset");
            check_value(32'({rdata3, rdata2, rdata1, rdata0}), 32'd0, "rdata in reset");
        end
        n_rst = 1'b1;
        repeat (4) begin
            next_cycle();
            check_value(32'(busy), 32'd0, "busy before first start");
            check_value(32'(dout_vld), 32'd0, "dout_vld before first start");
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_block(r);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- compile.f
verilog/hpav_interleaver_pkg.sv
verilog/interleave_sequencer.sv
verilog/permutation_generator.sv
verilog/bank_crossbar.sv
verilog/symbol_banks.sv
verilog/turbo_interleaver.sv
test/turbo_interleaver_properties.sv
test/tb_turbo_interleaver.sv

//--- Makefile
# Verilator build and run of the turbo interleaver testbench

TOP := tb_turbo_interleaver
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard verilog/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -j 0 -Mdir obj_dir \
		--top-module $(TOP) -f compile.f

# the log decides pass or fail
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir $(LOG)
